// ==== tb.f ====
rtl/rv_pkg.sv
rtl/rv_regfile.sv
rtl/rv_hazard_unit.sv
rtl/rv_controller.sv
rtl/rv_datapath.sv
rtl/rv_core_top.sv
testbench/rv_core_asserts.sv
testbench/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SIMULATION FAILED" $(LOG); then \
	  echo "run failed, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
	  echo "simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

  localparam logic [31:0] reset_pc = 32'h0000_0000;
  localparam logic [31:0] res_base = 32'h0000_0100;
  localparam logic [31:0] poison_addr = 32'h0000_0200;
  localparam logic [31:0] done_addr = 32'h0000_01f0;

  logic        clk;
  logic        rst_n;
  logic [31:0] idt;
  logic [31:0] rdata;
  logic [31:0] iad;
  logic [31:0] dad;
  logic [31:0] wdata;
  logic        mreq;
  logic        write;
  mem_size_e   size;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];

  logic [31:0] exp_val [logic [31:0]];
  string       exp_name [logic [31:0]];
  bit          seen [logic [31:0]];

  logic [31:0] prog_pc;
  int          prog_len;
  int          mismatches;
  int          failures;
  bit          done;

  rv_core_top #(
    .reset_pc(reset_pc)
  ) dut (
    .clk   (clk),
    .rst_n (rst_n),
    .idt   (idt),
    .rdata (rdata),
    .iad   (iad),
    .dad   (dad),
    .wdata (wdata),
    .mreq  (mreq),
    .write (write),
    .size  (size)
  );

  // zero-wait memories
  assign idt = imem[iad[9:2]];
  assign rdata = mreq ? dmem[dad[9:2]] : 32'd0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // instruction encoders for the rv32i formats
  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    rtype = {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    itype = {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    stype = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    btype = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    utype = {imm, rd, op};
  endfunction

  function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
    jtype = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[prog_pc[9:2]] = word;
    prog_pc = prog_pc + 32'd4;
  endtask

  // sw rs,off(x20) plus the value it must carry
  task automatic store_result(input logic [4:0] rs, input logic [11:0] off,
                              input string name, input logic [31:0] value);
    logic [31:0] addr;
    addr = res_base + {20'd0, off};
    emit(stype(off, rs, 5'd20, 3'b010));
    exp_val[addr] = value;
    exp_name[addr] = name;
    seen[addr] = 1'b0;
  endtask

  task automatic poison();
    emit(stype(poison_addr[11:0], 5'd22, 5'd0, 3'b010));
  endtask

  task automatic build_program();
    logic [31:0] link;
    for (int i = 0; i < 256; i++) begin
      // filler nops tagged with their own index
      imem[i] = itype(i[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011);
      dmem[i] = 32'ha5a5_0000 ^ i;
    end
    prog_pc = reset_pc;
    // back-to-back dependent alu ops
    emit(itype(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
    emit(itype(12'hffd, 5'd0, 3'b000, 5'd2, 7'b0010011));
    emit(rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    emit(rtype(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
    emit(rtype(7'h00, 5'd1, 5'd4, 3'b100, 5'd5));
    emit(rtype(7'h00, 5'd1, 5'd4, 3'b010, 5'd6));
    emit(rtype(7'h00, 5'd1, 5'd4, 3'b011, 5'd7));
    emit(rtype(7'h00, 5'd3, 5'd1, 3'b001, 5'd8));
    emit(rtype(7'h20, 5'd3, 5'd4, 3'b101, 5'd9));
    emit(rtype(7'h00, 5'd3, 5'd4, 3'b101, 5'd10));
    emit(utype(20'h12345, 5'd11, 7'b0110111));
    emit(itype(12'h100, 5'd0, 3'b000, 5'd20, 7'b0010011));
    store_result(5'd3, 12'd0, "add", 32'd2);
    store_result(5'd4, 12'd4, "sub", 32'hffff_fffd);
    store_result(5'd5, 12'd8, "xor", 32'hffff_fff8);
    store_result(5'd6, 12'd12, "slt", 32'd1);
    store_result(5'd7, 12'd16, "sltu", 32'd0);
    store_result(5'd8, 12'd20, "sll", 32'd20);
    store_result(5'd9, 12'd24, "sra", 32'hffff_ffff);
    store_result(5'd10, 12'd28, "srl", 32'h3fff_ffff);
    store_result(5'd11, 12'd32, "lui", 32'h1234_5000);
    // load-use and load extension on the data word at 0x80
    emit(itype(12'h080, 5'd0, 3'b000, 5'd21, 7'b0010011));
    emit(utype(20'h8081f, 5'd12, 7'b0110111));
    emit(itype(12'h2f3, 5'd12, 3'b000, 5'd12, 7'b0010011));
    emit(stype(12'd0, 5'd12, 5'd21, 3'b010));
    emit(itype(12'd0, 5'd21, 3'b010, 5'd13, 7'b0000011));
    emit(rtype(7'h00, 5'd1, 5'd13, 3'b000, 5'd14));
    store_result(5'd14, 12'd36, "load_use_add", 32'h8081_f2f8);
    emit(itype(12'd0, 5'd21, 3'b000, 5'd15, 7'b0000011));
    store_result(5'd15, 12'd40, "lb", 32'hffff_fff3);
    emit(itype(12'd1, 5'd21, 3'b100, 5'd16, 7'b0000011));
    store_result(5'd16, 12'd44, "lbu", 32'h0000_00f2);
    emit(itype(12'd2, 5'd21, 3'b001, 5'd17, 7'b0000011));
    store_result(5'd17, 12'd48, "lh", 32'hffff_8081);
    emit(itype(12'd2, 5'd21, 3'b101, 5'd18, 7'b0000011));
    store_result(5'd18, 12'd52, "lhu", 32'h0000_8081);
    // byte and half stores merged into the same word
    emit(stype(12'd1, 5'd1, 5'd21, 3'b000));
    emit(stype(12'd2, 5'd2, 5'd21, 3'b001));
    emit(itype(12'd0, 5'd21, 3'b010, 5'd19, 7'b0000011));
    store_result(5'd19, 12'd56, "sb_sh_merge", 32'hfffd_05f3);
    // branches with x22 as the marker
    emit(itype(12'd1, 5'd0, 3'b000, 5'd22, 7'b0010011));
    emit(btype(13'd8, 5'd1, 5'd1, 3'b000));
    poison();
    store_result(5'd22, 12'd60, "beq_taken", 32'd1);
    emit(btype(13'd8, 5'd2, 5'd1, 3'b000));
    store_result(5'd22, 12'd64, "beq_not_taken", 32'd1);
    emit(btype(13'd8, 5'd2, 5'd1, 3'b001));
    poison();
    store_result(5'd22, 12'd68, "bne_taken", 32'd1);
    emit(btype(13'd8, 5'd1, 5'd2, 3'b100));
    poison();
    store_result(5'd22, 12'd72, "blt_taken", 32'd1);
    emit(btype(13'd8, 5'd2, 5'd1, 3'b111));
    store_result(5'd22, 12'd76, "bgeu_not_taken", 32'd1);
    // jump links hold the jump address plus 4
    link = prog_pc + 32'd4;
    emit(jtype(21'd8, 5'd23));
    poison();
    store_result(5'd23, 12'd80, "jal_link", link);
    emit(utype(20'd0, 5'd24, 7'b0010111));
    link = prog_pc + 32'd4;
    emit(itype(12'd12, 5'd24, 3'b000, 5'd25, 7'b1100111));
    poison();
    store_result(5'd25, 12'd84, "jalr_link", link);
    emit(stype(done_addr[11:0], 5'd22, 5'd0, 3'b010));
    emit(jtype(21'd0, 5'd0));
    prog_len = int'((prog_pc - reset_pc) >> 2);
  endtask

  initial begin
    mismatches = 0;
    failures = 0;
    done = 1'b0;
    prog_len = 0;
    rst_n = 1'b0;
    build_program();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
  end

  // data memory writes and result checks on pre-edge port values
  always @(posedge clk) begin
    logic [3:0] lanes;
    if (rst_n && mreq && write) begin
      case (size)
        size_byte: lanes = 4'b0001 << dad[1:0];
        size_half: lanes = 4'b0011 << dad[1:0];
        default:   lanes = 4'b1111;
      endcase
      for (int b = 0; b < 4; b++) begin
        if (lanes[b]) begin
          dmem[dad[9:2]][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
      if (dad == poison_addr) begin
        failures++;
        $display("store from a flushed path reached the poison address");
      end else if (dad == done_addr) begin
        done <= 1'b1;
      end else if (exp_val.exists(dad)) begin
        seen[dad] = 1'b1;
        if (wdata !== exp_val[dad]) begin
          mismatches++;
          $display("mismatch %s: expected %h actual %h", exp_name[dad], exp_val[dad], wdata);
        end
      end else if (dad >= res_base && dad < done_addr) begin
        failures++;
        $display("store to results address %h that the program never targets", dad);
      end
    end
  end

  // watchdog sized from the program
  initial begin
    @(posedge rst_n);
    repeat (prog_len * 3 + 100) @(posedge clk);
    $display("timeout: the program never reached its done store");
    $display("errors: mismatches=%0d failures=%0d assertions=%0d", mismatches,
             failures + 1, dut.u_asserts.fail_count);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int total;
    @(posedge rst_n);
    while (!done) @(posedge clk);
    repeat (3) @(posedge clk);
    foreach (exp_val[a]) begin
      if (!seen[a]) begin
        failures++;
        $display("no store arrived at results address %h for %s", a, exp_name[a]);
      end
    end
    total = mismatches + failures + dut.u_asserts.fail_count;
    $display("errors: mismatches=%0d failures=%0d assertions=%0d", mismatches, failures,
             dut.u_asserts.fail_count);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/rv_core_asserts.sv ====
`timescale 1ns/1ps

module rv_core_asserts import rv_pkg::*; #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input logic        clk,
  input logic        rst_n,
  input logic [31:0] iad,
  input logic [31:0] dad,
  input logic        mreq,
  input logic        write,
  input mem_size_e   size,
  input hazard_t     hz,
  input ctrl_t       ctrl_e
);

  int fail_count = 0;

  // bus quiet while held in reset
  reset_quiet: assert property (@(posedge clk) !rst_n |-> (!mreq && !write))
    else begin
      fail_count = fail_count + 1;
      $error("mreq or write high during reset");
    end

  first_fetch: assert property (@(posedge clk) $rose(rst_n) |-> iad == reset_pc)
    else begin
      fail_count = fail_count + 1;
      $error("first fetch address is not reset_pc");
    end

  // sequential fetch when nothing holds or redirects
  // the edge that releases reset still loads reset_pc
  fetch_step: assert property (@(posedge clk) disable iff (!rst_n)
      (rst_n && !hz.stall_f && ctrl_e.pc_src == pc_seq) |=> iad == $past(iad) + 32'd4)
    else begin
      fail_count = fail_count + 1;
      $error("fetch address did not advance by 4");
    end

  write_has_req: assert property (@(posedge clk) disable iff (!rst_n) write |-> mreq)
    else begin
      fail_count = fail_count + 1;
      $error("write without mreq");
    end

  data_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      mreq |-> ((size == size_half && !dad[0]) || (size == size_word && dad[1:0] == 2'b00)
                || size == size_byte))
    else begin
      fail_count = fail_count + 1;
      $error("data address misaligned for its size");
    end

  fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n) iad[1:0] == 2'b00)
    else begin
      fail_count = fail_count + 1;
      $error("fetch address not word aligned");
    end

endmodule

bind rv_core_top rv_core_asserts #(
  .reset_pc(reset_pc)
) u_asserts (
  .clk    (clk),
  .rst_n  (rst_n),
  .iad    (iad),
  .dad    (dad),
  .mreq   (mreq),
  .write  (write),
  .size   (size),
  .hz     (hz),
  .ctrl_e (ctrl_e)
);

// ==== rtl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] idt,
  input  logic [31:0] rdata,
  output logic [31:0] iad,
  output logic [31:0] dad,
  output logic [31:0] wdata,
  output logic        mreq,
  output logic        write,
  output mem_size_e   size
);

  // datapath to controller and hazard unit
  inst_u     inst_d;
  logic      branch_taken_e;
  reg_addr_t regs;

  // per-stage control bundles
  ctrl_t     ctrl_d;
  ctrl_t     ctrl_e;
  ctrl_t     ctrl_m;
  ctrl_t     ctrl_w;
  imm_sel_e  imm_sel;

  hazard_t   hz;

  rv_datapath #(
    .reset_pc(reset_pc)
  ) u_datapath (
    .clk            (clk),
    .rst_n          (rst_n),
    .idt            (idt),
    .rdata          (rdata),
    .ctrl_d         (ctrl_d),
    .ctrl_e         (ctrl_e),
    .ctrl_m         (ctrl_m),
    .ctrl_w         (ctrl_w),
    .imm_sel        (imm_sel),
    .hz             (hz),
    .iad            (iad),
    .dad            (dad),
    .wdata          (wdata),
    .inst_d         (inst_d),
    .branch_taken_e (branch_taken_e),
    .regs           (regs)
  );

  rv_controller u_controller (
    .clk            (clk),
    .rst_n          (rst_n),
    .inst_d         (inst_d),
    .branch_taken_e (branch_taken_e),
    .hz             (hz),
    .ctrl_d         (ctrl_d),
    .ctrl_e         (ctrl_e),
    .ctrl_m         (ctrl_m),
    .ctrl_w         (ctrl_w),
    .imm_sel        (imm_sel),
    .mreq           (mreq),
    .write          (write),
    .size           (size)
  );

  rv_hazard_unit u_hazard_unit (
    .regs   (regs),
    .ctrl_e (ctrl_e),
    .ctrl_m (ctrl_m),
    .ctrl_w (ctrl_w),
    .hz     (hz)
  );

endmodule

// ==== rtl/rv_datapath.sv ====
`timescale 1ns/1ps

module rv_datapath import rv_pkg::*; #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] idt,
  input  logic [31:0] rdata,
  input  ctrl_t       ctrl_d,
  input  ctrl_t       ctrl_e,
  input  ctrl_t       ctrl_m,
  input  ctrl_t       ctrl_w,
  input  imm_sel_e    imm_sel,
  input  hazard_t     hz,
  output logic [31:0] iad,
  output logic [31:0] dad,
  output logic [31:0] wdata,
  output inst_u       inst_d,
  output logic        branch_taken_e,
  output reg_addr_t   regs
);

  logic [31:0] pc_f;
  logic [31:0] pc_d, imm_d, rd1_d, rd2_d;
  logic [4:0]  rs1_d, rs2_d;
  logic [31:0] pc_e, imm_e, rd1_e, rd2_e;
  logic [4:0]  rs1_e, rs2_e, rd_e;
  logic [31:0] opa_e, opb_e, src_a, src_b, alu_y, target_e;
  logic [31:0] alu_m, store_m, pc4_m, fwd_m, rdata_sh, load_m;
  logic [4:0]  rd_m;
  logic [31:0] alu_w, load_w, pc4_w, result_w;
  logic [4:0]  rd_w;

  // fetch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_f <= reset_pc;
    end else if (ctrl_e.pc_src != pc_seq) begin
      pc_f <= target_e;
    end else if (!hz.stall_f) begin
      pc_f <= pc_f + 32'd4;
    end
  end

  assign iad = pc_f;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_d <= '0;
    end else if (hz.flush_d) begin
      inst_d <= '0;
    end else if (!hz.stall_d) begin
      inst_d <= idt;
    end
  end

  always_ff @(posedge clk) begin
    if (!hz.stall_d) begin
      pc_d <= pc_f;
    end
  end

  // decode
  // sources the instruction does not read are reported as x0
  assign rs1_d = ctrl_d.a_src_pc ? 5'd0 : inst_d.r.rs1;
  assign rs2_d = (ctrl_d.alu_src_imm && !ctrl_d.mem_write) ? 5'd0 : inst_d.r.rs2;

  rv_regfile u_regfile (
    .clk   (clk),
    .rst_n (rst_n),
    .ra1   (inst_d.r.rs1),
    .ra2   (inst_d.r.rs2),
    .rd1   (rd1_d),
    .rd2   (rd2_d),
    .we    (ctrl_w.reg_write),
    .wa    (rd_w),
    .wd    (result_w)
  );

  always_comb begin
    case (imm_sel)
      imm_i: imm_d = {{20{inst_d.i.imm[11]}}, inst_d.i.imm};
      imm_s: imm_d = {{20{inst_d.s.imm_hi[6]}}, inst_d.s.imm_hi, inst_d.s.imm_lo};
      imm_b: imm_d = {{20{inst_d.b.imm12}}, inst_d.b.imm11, inst_d.b.imm10_5,
                      inst_d.b.imm4_1, 1'b0};
      imm_u: imm_d = {inst_d.u.imm, 12'd0};
      imm_j: imm_d = {{12{inst_d.j.imm20}}, inst_d.j.imm19_12, inst_d.j.imm11,
                      inst_d.j.imm10_1, 1'b0};
      default: imm_d = '0;
    endcase
  end

  // register addresses along the pipe, cleared with the bubble
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rs1_e <= '0;
      rs2_e <= '0;
      rd_e <= '0;
      rd_m <= '0;
      rd_w <= '0;
    end else begin
      rs1_e <= hz.flush_e ? 5'd0 : rs1_d;
      rs2_e <= hz.flush_e ? 5'd0 : rs2_d;
      rd_e <= hz.flush_e ? 5'd0 : inst_d.r.rd;
      rd_m <= rd_e;
      rd_w <= rd_m;
    end
  end

  always_ff @(posedge clk) begin
    pc_e <= pc_d;
    imm_e <= imm_d;
    rd1_e <= rd1_d;
    rd2_e <= rd2_d;
  end

  // execute
  always_comb begin
    case (hz.fwd_a)
      fwd_mem: opa_e = fwd_m;
      fwd_wb:  opa_e = result_w;
      default: opa_e = rd1_e;
    endcase
    case (hz.fwd_b)
      fwd_mem: opb_e = fwd_m;
      fwd_wb:  opb_e = result_w;
      default: opb_e = rd2_e;
    endcase
  end

  assign src_a = ctrl_e.a_src_pc ? pc_e : opa_e;
  assign src_b = ctrl_e.alu_src_imm ? imm_e : opb_e;

  always_comb begin
    case (ctrl_e.alu_op)
      alu_add:    alu_y = src_a + src_b;
      alu_sub:    alu_y = src_a - src_b;
      alu_sll:    alu_y = src_a << src_b[4:0];
      alu_slt:    alu_y = {31'd0, $signed(src_a) < $signed(src_b)};
      alu_sltu:   alu_y = {31'd0, src_a < src_b};
      alu_xor:    alu_y = src_a ^ src_b;
      alu_srl:    alu_y = src_a >> src_b[4:0];
      alu_sra:    alu_y = $unsigned($signed(src_a) >>> src_b[4:0]);
      alu_or:     alu_y = src_a | src_b;
      alu_and:    alu_y = src_a & src_b;
      alu_pass_b: alu_y = src_b;
      default:    alu_y = '0;
    endcase
  end

  always_comb begin
    case (ctrl_e.branch_funct3)
      3'b000:  branch_taken_e = (opa_e == opb_e);
      3'b001:  branch_taken_e = (opa_e != opb_e);
      3'b100:  branch_taken_e = ($signed(opa_e) < $signed(opb_e));
      3'b101:  branch_taken_e = ($signed(opa_e) >= $signed(opb_e));
      3'b110:  branch_taken_e = (opa_e < opb_e);
      3'b111:  branch_taken_e = (opa_e >= opb_e);
      default: branch_taken_e = 1'b0;
    endcase
  end

  // jalr drops bit 0 of the sum
  assign target_e = (ctrl_e.pc_src == pc_jalr) ? ((opa_e + imm_e) & ~32'd1)
                                               : (pc_e + imm_e);

  always_ff @(posedge clk) begin
    alu_m <= alu_y;
    store_m <= opb_e;
    pc4_m <= pc_e + 32'd4;
  end

  // memory
  assign dad = alu_m;
  assign wdata = store_m << {alu_m[1:0], 3'b000};
  assign fwd_m = (ctrl_m.result_src == res_pc4) ? pc4_m : alu_m;
  assign rdata_sh = rdata >> {alu_m[1:0], 3'b000};

  always_comb begin
    case (ctrl_m.mem_size)
      size_byte: load_m = {{24{ctrl_m.load_signed & rdata_sh[7]}}, rdata_sh[7:0]};
      size_half: load_m = {{16{ctrl_m.load_signed & rdata_sh[15]}}, rdata_sh[15:0]};
      default:   load_m = rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    alu_w <= alu_m;
    load_w <= load_m;
    pc4_w <= pc4_m;
  end

  // writeback
  always_comb begin
    case (ctrl_w.result_src)
      res_mem: result_w = load_w;
      res_pc4: result_w = pc4_w;
      default: result_w = alu_w;
    endcase
  end

  always_comb begin
    regs.d_rs1 = rs1_d;
    regs.d_rs2 = rs2_d;
    regs.e_rs1 = rs1_e;
    regs.e_rs2 = rs2_e;
    regs.e_rd = rd_e;
    regs.m_rd = rd_m;
    regs.w_rd = rd_w;
  end

endmodule

// ==== rtl/rv_controller.sv ====
`timescale 1ns/1ps

module rv_controller import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  inst_u    inst_d,
  input  logic     branch_taken_e,
  input  hazard_t  hz,
  output ctrl_t    ctrl_d,
  output ctrl_t    ctrl_e,
  output ctrl_t    ctrl_m,
  output ctrl_t    ctrl_w,
  output imm_sel_e imm_sel,
  output logic     mreq,
  output logic     write,
  output mem_size_e size
);

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  ctrl_t ctrl_e_q;

  // funct7[5] means sub only for register ops, sra for both
  function automatic alu_op_e decode_alu(input logic [2:0] f3, input logic f7_5,
                                         input logic is_reg);
    case (f3)
      3'b000:  decode_alu = (is_reg && f7_5) ? alu_sub : alu_add;
      3'b001:  decode_alu = alu_sll;
      3'b010:  decode_alu = alu_slt;
      3'b011:  decode_alu = alu_sltu;
      3'b100:  decode_alu = alu_xor;
      3'b101:  decode_alu = f7_5 ? alu_sra : alu_srl;
      3'b110:  decode_alu = alu_or;
      default: decode_alu = alu_and;
    endcase
  endfunction

  // unknown opcodes (and the all-zero bubble) decode to an empty bundle
  always_comb begin
    ctrl_d = '0;
    imm_sel = imm_i;
    case (inst_d.r.opcode)
      op_lui, op_auipc: begin
        ctrl_d.alu_op = (inst_d.r.opcode == op_lui) ? alu_pass_b : alu_add;
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.a_src_pc = 1'b1;
        ctrl_d.reg_write = 1'b1;
        imm_sel = imm_u;
      end
      op_jal, op_jalr: begin
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.a_src_pc = (inst_d.r.opcode == op_jal);
        ctrl_d.pc_src = (inst_d.r.opcode == op_jal) ? pc_jal : pc_jalr;
        ctrl_d.result_src = res_pc4;
        ctrl_d.reg_write = 1'b1;
        imm_sel = (inst_d.r.opcode == op_jal) ? imm_j : imm_i;
      end
      op_branch: begin
        ctrl_d.pc_src = pc_branch;
        ctrl_d.branch_funct3 = inst_d.b.funct3;
        imm_sel = imm_b;
      end
      op_load, op_store: begin
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.mem_req = 1'b1;
        ctrl_d.mem_write = (inst_d.r.opcode == op_store);
        ctrl_d.mem_size = mem_size_e'(inst_d.i.funct3[1:0]);
        ctrl_d.load_signed = !inst_d.i.funct3[2];
        ctrl_d.result_src = res_mem;
        ctrl_d.reg_write = (inst_d.r.opcode == op_load);
        imm_sel = (inst_d.r.opcode == op_store) ? imm_s : imm_i;
      end
      op_imm, op_reg: begin
        ctrl_d.alu_op = decode_alu(inst_d.r.funct3, inst_d.r.funct7[5],
                                   inst_d.r.opcode == op_reg);
        ctrl_d.alu_src_imm = (inst_d.r.opcode == op_imm);
        ctrl_d.reg_write = 1'b1;
      end
      default: ;
    endcase
  end

  // flush_e covers both the branch flush and the load-use bubble
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_e_q <= '0;
      ctrl_m <= '0;
      ctrl_w <= '0;
    end else begin
      ctrl_e_q <= hz.flush_e ? '0 : ctrl_d;
      ctrl_m <= ctrl_e;
      ctrl_w <= ctrl_m;
    end
  end

  // a branch that is not taken falls through
  always_comb begin
    ctrl_e = ctrl_e_q;
    if (ctrl_e_q.pc_src == pc_branch && !branch_taken_e) begin
      ctrl_e.pc_src = pc_seq;
    end
  end

  assign mreq = ctrl_m.mem_req;
  assign write = ctrl_m.mem_write;
  assign size = ctrl_m.mem_size;

endmodule

// ==== rtl/rv_hazard_unit.sv ====
`timescale 1ns/1ps

module rv_hazard_unit import rv_pkg::*; (
  input  reg_addr_t regs,
  input  ctrl_t     ctrl_e,
  input  ctrl_t     ctrl_m,
  input  ctrl_t     ctrl_w,
  output hazard_t   hz
);

  logic load_use;
  logic redirect;

  // youngest producer wins, x0 never forwards
  function automatic fwd_sel_e pick_fwd(input logic [4:0] rs);
    if (rs != 5'd0 && ctrl_m.reg_write && rs == regs.m_rd) begin
      pick_fwd = fwd_mem;
    end else if (rs != 5'd0 && ctrl_w.reg_write && rs == regs.w_rd) begin
      pick_fwd = fwd_wb;
    end else begin
      pick_fwd = fwd_reg;
    end
  endfunction

  // load in execute feeding the instruction in decode
  assign load_use = ctrl_e.reg_write && ctrl_e.result_src == res_mem &&
                    regs.e_rd != 5'd0 &&
                    (regs.e_rd == regs.d_rs1 || regs.e_rd == regs.d_rs2);

  // pc_src is already qualified by the branch outcome
  assign redirect = (ctrl_e.pc_src != pc_seq);

  always_comb begin
    hz.fwd_a = pick_fwd(regs.e_rs1);
    hz.fwd_b = pick_fwd(regs.e_rs2);
    hz.stall_f = load_use;
    hz.stall_d = load_use;
    hz.flush_d = redirect;
    hz.flush_e = redirect || load_use;
  end

endmodule

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  output logic [31:0] rd1,
  output logic [31:0] rd2,
  input  logic        we,
  input  logic [4:0]  wa,
  input  logic [31:0] wd
);

  // x0 has no storage
  logic [31:0] rf [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (we && wa != 5'd0) begin
      rf[wa] <= wd;
    end
  end

  // same-cycle write is visible to decode
  function automatic logic [31:0] read_reg(input logic [4:0] ra);
    if (ra == 5'd0) begin
      read_reg = '0;
    end else if (we && wa == ra) begin
      read_reg = wd;
    end else begin
      read_reg = rf[ra];
    end
  endfunction

  always_comb rd1 = read_reg(ra1);
  always_comb rd2 = read_reg(ra2);

endmodule

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

  // rv32i instruction formats, all views of one 32-bit word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {res_alu, res_mem, res_pc4} result_src_e;
  // pc_branch is only a candidate until execute qualifies it
  typedef enum logic [1:0] {pc_seq, pc_branch, pc_jal, pc_jalr} pc_src_e;
  typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb} fwd_sel_e;
  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_sel_e;
  // encoding matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

  typedef struct packed {
    alu_op_e     alu_op;
    logic        alu_src_imm;
    logic        a_src_pc;
    pc_src_e     pc_src;
    logic [2:0]  branch_funct3;
    logic        mem_req;
    logic        mem_write;
    mem_size_e   mem_size;
    logic        load_signed;
    result_src_e result_src;
    logic        reg_write;
  } ctrl_t;

  typedef struct packed {
    logic     stall_f;
    logic     stall_d;
    logic     flush_d;
    logic     flush_e;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
  } hazard_t;

  typedef struct packed {
    logic [4:0] d_rs1;
    logic [4:0] d_rs2;
    logic [4:0] e_rs1;
    logic [4:0] e_rs2;
    logic [4:0] e_rd;
    logic [4:0] m_rd;
    logic [4:0] w_rd;
  } reg_addr_t;

endpackage
